// File: Bender.yml
package:
  name: poly_actor

sources:
  - verilog/poly_pkg.sv
  - verilog/token_buffer.sv
  - verilog/command_decoder.sv
  - verilog/poly_engine.sv
  - verilog/firing_controller.sv
  - verilog/result_writer.sv
  - verilog/poly_actor.sv
  - target: simulation
    files:
      - bench/poly_actor_tb.sv

// File: bench/poly_actor_tb.sv
module poly_actor_tb
    import poly_pkg::*;
();

    localparam int drive_delay = 1;
    localparam int timeout_cycles = 20000;             // About ten times the longest sequence.

    logic clk = 1'b0;
    logic rst;
    word_t data_in = '0;
    word_t data_pop = '0;
    logic data_rd;
    word_t command_in = '0;
    word_t command_pop = '0;
    logic command_rd;
    logic start;
    mode_t mode;
    logic done;
    logic result_wr;
    word_t result;
    word_t status;

    word_t data_q[$];
    word_t cmd_q[$];
    out_token_t exp_q[$];
    out_token_t head;
    logic data_rd_seen = 1'b0;
    logic command_rd_seen = 1'b0;
    logic busy;                                        // Parent waits for a done.
    integer seed = 32'hfd15c3ed;
    int cycle_count = 0;

    // Reference slot contents.
    word_t model_coef [SLOTS][MAX_COEFFS];
    int model_deg [SLOTS];
    logic model_valid [SLOTS];

    poly_actor #(.buffer_depth(16)) dut_i (
        .clk(clk), .rst(rst), .data_in(data_in), .data_pop(data_pop), .data_rd(data_rd),
        .command_in(command_in), .command_pop(command_pop), .command_rd(command_rd),
        .start(start), .mode(mode), .done(done), .result_wr(result_wr),
        .result(result), .status(status)
    );

    always #50 clk = ~clk;

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input word_t expected, input word_t actual);
        abort_run($sformatf("FAIL %s: expected %h, got %h", name, expected, actual));
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
            abort_run("Timeout: the run did not finish within the cycle limit.");
    end

    ////////////////////
    // Input FIFO models
    ////////////////////

    // Strobes are stable at the falling edge.
    always @(negedge clk)
    begin
        data_rd_seen = data_rd;
        command_rd_seen = command_rd;
    end

    always @(posedge clk)
    begin
        #drive_delay;
        if (data_rd_seen)
            data_in = data_q.pop_front();              // Head shows the cycle after the strobe.
        if (command_rd_seen)
            command_in = cmd_q.pop_front();
        data_pop = word_t'(data_q.size());
        command_pop = word_t'(cmd_q.size());
    end

    ////////////////////
    // Checks
    ////////////////////

    assert property (@(posedge clk) disable iff (!rst) !(data_rd && data_pop == '0))
        else abort_run("data_rd went high while the data FIFO was empty.");
    assert property (@(posedge clk) disable iff (!rst) !(command_rd && command_pop == '0))
        else abort_run("command_rd went high while the command FIFO was empty.");
    assert property (@(posedge clk) disable iff (!rst) done |-> busy)
        else abort_run("done pulsed without a matching start.");

    // Each output write takes the oldest expected token.
    always @(negedge clk)
    begin
        if (rst && result_wr)
        begin
            assert (exp_q.size() != 0)
                else abort_run("result_wr pulsed with no expected token queued.");
            head = exp_q.pop_front();
            assert (result == head.result) else value_mismatch("result", head.result, result);
            assert (status == word_t'(head.status))
                else value_mismatch("status", word_t'(head.status), status);
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic word_t model_eval(input int slot, input word_t x);
        word_t acc;
        acc = '0;
        for (int i = model_deg[slot]; i >= 0; i--)
            acc = acc * x + model_coef[slot][i];       // Horner from cN down.
        return acc;
    endfunction

    function automatic out_token_t expected_point(input int slot, input word_t x);
        out_token_t t;
        if (model_valid[slot])
            t = '{result: model_eval(slot, x), status: STATUS_OK};
        else
            t = '{result: '0, status: STATUS_EMPTY_SLOT};
        return t;
    endfunction

    function automatic word_t command_word(input logic [7:0] code, input int slot,
                                           input int count);
        command_t c;
        c.instr = instr_t'(code);
        c.slot = slot_t'(slot);
        c.count = count_t'(count);
        return word_t'(c);
    endfunction

    ////////////////////
    // Parent scheduler
    ////////////////////

    task automatic run_actor(input mode_t m);
        @(posedge clk);
        #drive_delay;
        start = 1'b1;
        mode = m;
        busy = 1'b1;
        @(posedge clk);
        #drive_delay;
        start = 1'b0;
        do
            @(negedge clk);
        while (!done);
        @(posedge clk);
        #drive_delay;
        busy = 1'b0;
        @(negedge clk);                                // Last result_wr lands here.
        @(posedge clk);
        assert (exp_q.size() == 0)
            else abort_run($sformatf("%0d expected tokens not written before done.",
                                     exp_q.size()));
    endtask

    task automatic setup_command(input word_t w);
        cmd_q.push_back(w);
        run_actor(MODE_SETUP);
    endtask

    task automatic store_poly(input int slot, input int n);
        word_t c;
        setup_command(command_word(STP, slot, n));
        if (n < MAX_COEFFS)
        begin
            model_deg[slot] = n;
            for (int i = 0; i <= n; i++)
            begin
                c = word_t'($random(seed));
                model_coef[slot][i] = c;
                data_q.push_back(c);                   // c0 goes first.
            end
            model_valid[slot] = 1'b1;
            exp_q.push_back('{result: word_t'(n + 1), status: STATUS_OK});
        end
        else
            exp_q.push_back('{result: '0, status: STATUS_BAD_LENGTH});
        run_actor(MODE_FIRE);
    endtask

    task automatic eval_point(input int slot);
        word_t x;
        setup_command(command_word(EVP, slot, 0));
        x = word_t'($random(seed));
        data_q.push_back(x);
        exp_q.push_back(expected_point(slot, x));
        run_actor(MODE_FIRE);
    endtask

    // With stall set, only two values are ready when the block starts.
    task automatic eval_block(input int slot, input int b, input logic stall);
        word_t xs[$];
        int values;
        values = (b == 0) ? 1 : b;
        setup_command(command_word(EVB, slot, b));
        for (int i = 0; i < values; i++)
        begin
            xs.push_back(word_t'($random(seed)));
            exp_q.push_back(expected_point(slot, xs[i]));
        end
        if (stall)
        begin
            data_q.push_back(xs[0]);
            data_q.push_back(xs[1]);
            fork
                run_actor(MODE_FIRE);
                begin
                    repeat (40) @(negedge clk);
                    for (int i = 2; i < values; i++)
                        data_q.push_back(xs[i]);
                end
            join
        end
        else
        begin
            foreach (xs[i])
                data_q.push_back(xs[i]);
            run_actor(MODE_FIRE);
        end
    endtask

    task automatic clear_slots();
        setup_command(command_word(RST, 0, 0));
        foreach (model_valid[s])
            model_valid[s] = 1'b0;
        run_actor(MODE_FIRE);
    endtask

    task automatic unknown_op(input logic [7:0] code);
        setup_command(command_word(code, 0, 0));
        run_actor(MODE_FIRE);                          // Done only and no output write.
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial
    begin
        rst = 1'b0;
        start = 1'b0;
        mode = MODE_SETUP;
        busy = 1'b0;
        foreach (model_valid[s])
            model_valid[s] = 1'b0;
        repeat (4) @(posedge clk);
        #drive_delay;
        rst = 1'b1;
        repeat (10) @(posedge clk);                    // Quiet period before the first start.

        store_poly(0, $unsigned($random(seed)) % 11);
        repeat (3) eval_point(0);

        store_poly(2, $unsigned($random(seed)) % 11);
        eval_block(2, 1 + $unsigned($random(seed)) % 8, 1'b0);
        eval_block(0, 3 + $unsigned($random(seed)) % 6, 1'b1);
        eval_block(2, 0, 1'b0);

        eval_point(5);
        store_poly(0, 12);
        eval_point(0);

        clear_slots();
        eval_point(0);
        eval_point(2);

        unknown_op(8'h7e);
        store_poly(1, 10);
        eval_point(1);

        repeat (5) @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: files.f
verilog/poly_pkg.sv
verilog/token_buffer.sv
verilog/command_decoder.sv
verilog/poly_engine.sv
verilog/firing_controller.sv
verilog/result_writer.sv
verilog/poly_actor.sv
bench/poly_actor_tb.sv

// File: verilog/command_decoder.sv
module command_decoder
    import poly_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start_fetch,
    input  logic     avail,
    input  word_t    word,
    output logic     pop,
    output command_t cmd,
    output logic     fetch_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_avail,
        st_capture
    } state_t;

    state_t state;

    // Exactly one pop per fetch.
    assign pop = (state == st_wait_avail) && avail;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= st_idle;
            cmd <= '0;
            fetch_done <= 1'b0;
        end
        else
        begin
            fetch_done <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (start_fetch)
                        state <= st_wait_avail;
                end
                st_wait_avail:
                begin
                    if (avail)
                        state <= st_capture;   // Stalls here while the buffer is empty.
                end
                st_capture:
                begin
                    cmd <= command_t'(word);   // Buffer output now holds the popped word.
                    fetch_done <= 1'b1;
                    state <= st_idle;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: verilog/firing_controller.sv
module firing_controller
    import poly_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  mode_t    mode,
    input  command_t cmd,
    input  logic     fetch_done,
    input  logic     item_done,
    input  logic     op_done,
    output logic     start_fetch,
    output logic     start_op,
    output logic     out_wr,
    output logic     done
);

    typedef enum logic [3:0] {
        st_idle,
        st_fetch_start,
        st_fetch_wait,
        st_fetch_finish,
        st_op_start,
        st_op_wait,
        st_item_output,
        st_output,
        st_skip
    } state_t;

    state_t state;
    state_t next_state;
    state_t op_end;

    // RST has no token to write.
    assign op_end = (cmd.instr == RST) ? st_skip : st_output;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= st_idle;
        else
            state <= next_state;
    end

    ////////////////////
    // Next state
    ////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:
            begin
                if (start && mode == MODE_SETUP)
                    next_state = st_fetch_start;
                else if (start && mode == MODE_FIRE)
                begin
                    case (cmd.instr)
                        STP, EVP, EVB, RST:
                            next_state = st_op_start;
                        default:
                            next_state = st_skip;      // Unknown code, done only.
                    endcase
                end
            end
            st_fetch_start:
                next_state = st_fetch_wait;
            st_fetch_wait:
            begin
                if (fetch_done)
                    next_state = st_fetch_finish;
            end
            st_op_start:
                next_state = st_op_wait;
            st_op_wait, st_item_output:
            begin
                if (op_done)
                    next_state = op_end;
                else if (item_done)
                    next_state = st_item_output;       // One EVB value ready.
                else
                    next_state = st_op_wait;
            end
            default:
                next_state = st_idle;
        endcase
    end

    // Outputs depend on the state only.
    assign start_fetch = (state == st_fetch_start);
    assign start_op = (state == st_op_start);
    assign out_wr = (state == st_item_output) || (state == st_output);
    assign done = (state == st_fetch_finish) || (state == st_output) || (state == st_skip);

endmodule

// File: verilog/poly_actor.sv
module poly_actor
    import poly_pkg::*;
#(
    parameter int buffer_depth = 16
)
(
    input  logic  clk,
    input  logic  rst,
    input  word_t data_in,
    input  word_t data_pop,
    output logic  data_rd,
    input  word_t command_in,
    input  word_t command_pop,
    output logic  command_rd,
    input  logic  start,
    input  mode_t mode,
    output logic  done,
    output logic  result_wr,
    output word_t result,
    output word_t status
);

    logic       data_avail;
    word_t      data_word;
    logic       eng_pop;
    logic       cmd_avail;
    word_t      cmd_word;
    logic       dec_pop;
    command_t   cmd;
    logic       start_fetch;
    logic       fetch_done;
    logic       start_op;
    logic       item_done;
    logic       op_done;
    logic       out_wr;
    out_token_t token;

    ////////////////////
    // Input side
    ////////////////////

    token_buffer #(.buffer_depth(buffer_depth)) data_buf_i (
        .clk(clk), .rst(rst), .fifo_word(data_in), .fifo_pop(data_pop), .fifo_rd(data_rd),
        .pop(eng_pop), .avail(data_avail), .word(data_word)
    );

    token_buffer #(.buffer_depth(buffer_depth)) cmd_buf_i (
        .clk(clk), .rst(rst), .fifo_word(command_in), .fifo_pop(command_pop),
        .fifo_rd(command_rd), .pop(dec_pop), .avail(cmd_avail), .word(cmd_word)
    );

    ////////////////////
    // Processing
    ////////////////////

    command_decoder decoder_i (
        .clk(clk), .rst(rst), .start_fetch(start_fetch), .avail(cmd_avail), .word(cmd_word),
        .pop(dec_pop), .cmd(cmd), .fetch_done(fetch_done)
    );

    poly_engine engine_i (
        .clk(clk), .rst(rst), .start(start_op), .cmd(cmd), .avail(data_avail),
        .word(data_word), .pop(eng_pop), .item_done(item_done), .op_done(op_done),
        .token(token)
    );

    firing_controller controller_i (
        .clk(clk), .rst(rst), .start(start), .mode(mode), .cmd(cmd),
        .fetch_done(fetch_done), .item_done(item_done), .op_done(op_done),
        .start_fetch(start_fetch), .start_op(start_op), .out_wr(out_wr), .done(done)
    );

    // Output side.
    result_writer writer_i (
        .clk(clk), .rst(rst), .out_wr(out_wr), .token(token),
        .result_wr(result_wr), .result(result), .status(status)
    );

endmodule

// File: verilog/poly_engine.sv
module poly_engine
    import poly_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  command_t   cmd,                            // Held by the decoder during the op.
    input  logic       avail,
    input  word_t      word,
    output logic       pop,
    output logic       item_done,
    output logic       op_done,
    output out_token_t token
);

    typedef enum logic [2:0] {
        st_idle,
        st_stp_pop,
        st_stp_write,
        st_x_pop,
        st_x_load,
        st_horner,
        st_finish
    } state_t;

    state_t state;
    word_t coeff [COEFF_WORDS];                        // Slot s starts at s * MAX_COEFFS.
    count_t degree [SLOTS];
    logic [SLOTS-1:0] valid;
    count_t idx;                                       // Coefficient index within the slot.
    count_t remaining;                                 // Values left in the block.
    word_t x;
    word_t acc;
    word_t horner;
    coeff_addr_t addr;

    assign addr = coeff_addr_t'(cmd.slot) * coeff_addr_t'(MAX_COEFFS) + coeff_addr_t'(idx);
    assign horner = acc * x + coeff[addr];             // Wraps modulo 2^16.
    assign pop = avail && (state == st_stp_pop || state == st_x_pop);

    ////////////////////
    // Sequencing
    ////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= st_idle;
            valid <= '0;
            idx <= '0;
            remaining <= '0;
            item_done <= 1'b0;
            op_done <= 1'b0;
        end
        else
        begin
            item_done <= 1'b0;
            op_done <= 1'b0;
            case (state)
                st_idle:
                begin
                    idx <= '0;
                    remaining <= count_t'(1);
                    if (start)
                    begin
                        case (cmd.instr)
                            STP:
                                state <= (cmd.count >= count_t'(MAX_COEFFS)) ? st_finish
                                                                             : st_stp_pop;
                            EVP:
                                state <= st_x_pop;
                            EVB:
                            begin
                                if (cmd.count != '0)
                                    remaining <= cmd.count;   // Zero runs as one.
                                state <= st_x_pop;
                            end
                            RST:
                            begin
                                valid <= '0;
                                state <= st_finish;
                            end
                            default:
                                state <= st_idle;
                        endcase
                    end
                end
                st_stp_pop:
                begin
                    if (avail)
                        state <= st_stp_write;
                end
                st_stp_write:
                begin
                    if (idx == cmd.count)
                    begin
                        valid[cmd.slot] <= 1'b1;
                        state <= st_finish;
                    end
                    else
                    begin
                        idx <= idx + 1'b1;
                        state <= st_stp_pop;
                    end
                end
                st_x_pop:
                begin
                    if (avail)
                        state <= st_x_load;
                end
                st_x_load:
                begin
                    idx <= degree[cmd.slot];           // Horner starts at cN.
                    state <= valid[cmd.slot] ? st_horner : st_finish;
                end
                st_horner:
                begin
                    if (idx == '0)
                        state <= st_finish;
                    else
                        idx <= idx - 1'b1;
                end
                st_finish:
                begin
                    if (remaining > count_t'(1))
                    begin
                        remaining <= remaining - 1'b1;
                        item_done <= 1'b1;
                        state <= st_x_pop;
                    end
                    else
                    begin
                        op_done <= 1'b1;
                        state <= st_idle;
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    ////////////////////
    // Store and datapath
    ////////////////////

    always_ff @(posedge clk)
    begin
        case (state)
            st_idle:
            begin
                if (start && cmd.instr == STP && cmd.count >= count_t'(MAX_COEFFS))
                    token <= '{result: '0, status: STATUS_BAD_LENGTH};
            end
            st_stp_write:
            begin
                coeff[addr] <= word;                   // Coefficients arrive c0 first.
                if (idx == cmd.count)
                begin
                    degree[cmd.slot] <= cmd.count;
                    token <= '{result: word_t'(cmd.count) + 16'd1, status: STATUS_OK};
                end
            end
            st_x_load:
            begin
                x <= word;
                acc <= '0;
                if (!valid[cmd.slot])
                    token <= '{result: '0, status: STATUS_EMPTY_SLOT};
            end
            st_horner:
            begin
                acc <= horner;
                if (idx == '0)
                    token <= '{result: horner, status: STATUS_OK};
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/poly_pkg.sv
package poly_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int SLOTS = 8;
    localparam int MAX_COEFFS = 11;                    // Degree 10 at most.
    localparam int COEFF_WORDS = SLOTS * MAX_COEFFS;

    typedef logic [15:0] word_t;                       // Data, coefficient, result or command.
    typedef logic [2:0] slot_t;
    typedef logic [4:0] count_t;                       // Degree for STP, block size for EVB.
    typedef logic [$clog2(COEFF_WORDS)-1:0] coeff_addr_t;

    ////////////////////
    // Encodings
    ////////////////////

    typedef enum logic [7:0] {
        STP = 8'd0,
        EVP = 8'd1,
        EVB = 8'd2,
        RST = 8'd3
    } instr_t;

    typedef enum logic [1:0] {
        MODE_SETUP = 2'd0,
        MODE_FIRE  = 2'd1
    } mode_t;

    typedef enum logic [15:0] {
        STATUS_OK         = 16'd0,
        STATUS_EMPTY_SLOT = 16'd1,
        STATUS_BAD_LENGTH = 16'd2
    } status_t;

    // One command word.
    typedef struct packed {
        instr_t instr;
        slot_t  slot;
        count_t count;
    } command_t;

    typedef struct packed {
        word_t   result;
        status_t status;
    } out_token_t;

endpackage

// File: verilog/result_writer.sv
module result_writer
    import poly_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       out_wr,
    input  out_token_t token,
    output logic       result_wr,
    output word_t      result,
    output word_t      status
);

    // Strobe and data leave on the same cycle.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            result_wr <= 1'b0;
        end
        else
        begin
            result_wr <= out_wr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (out_wr)
        begin
            result <= token.result;
            status <= word_t'(token.status);   // Status FIFO takes plain words.
        end
    end

endmodule

// File: verilog/token_buffer.sv
module token_buffer
    import poly_pkg::*;
#(
    parameter int buffer_depth = 16
)
(
    input  logic  clk,
    input  logic  rst,
    input  word_t fifo_word,                           // Valid the cycle after fifo_rd.
    input  word_t fifo_pop,                            // External FIFO population.
    output logic  fifo_rd,
    input  logic  pop,
    output logic  avail,
    output word_t word
);

    localparam int ptr_width = $clog2(buffer_depth);
    localparam int count_width = $clog2(buffer_depth + 1);

    word_t store [buffer_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [count_width-1:0] fill;
    logic pending;                                     // FIFO word lands this cycle.
    logic take;

    // A read in flight already owns one free entry.
    assign fifo_rd = (fifo_pop != '0)
                  && ((fill + count_width'(pending)) < count_width'(buffer_depth));
    assign avail = (fill != '0);
    assign take = pop && avail;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            pending <= 1'b0;
        end
        else
        begin
            pending <= fifo_rd;
            if (pending)
                wr_ptr <= (wr_ptr == ptr_width'(buffer_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (take)
                rd_ptr <= (rd_ptr == ptr_width'(buffer_depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (pending && !take)
                fill <= fill + 1'b1;
            else if (take && !pending)
                fill <= fill - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pending)
            store[wr_ptr] <= fifo_word;
        if (take)
            word <= store[rd_ptr];                     // Popped word shows next cycle.
    end

endmodule
